//--- Makefile
VERILATOR ?= verilator
TOP       ?= csr_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

//--- design/csr_defs.svh
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// datapath and field widths
`define CSR_DW          32
`define CSR_TIMER_W     32
`define CSR_NUM_W       14
`define CSR_HWI_N       8

// only DA set, translation off out of reset
`define CSR_CRMD_RST    9'h008

`endif

//--- design/csr_issue.sv
`include "csr_defs.svh"

module csr_issue
(
    input  logic               clk,
    input  logic               rstn,
    input  logic               op_valid,
    input  excp_pkg::csr_op_e  op,
    input  csr_pkg::csr_arg_u  arg,
    input  logic [`CSR_DW-1:0] pc,
    input  logic               stall,
    input  logic               flush,
    input  logic               int_pending,
    input  logic               crmd_ie,
    input  logic [`CSR_DW-1:0] era,
    input  logic [`CSR_DW-1:0] eentry,
    output logic               st_valid,
    output excp_pkg::csr_op_e  st_op,
    output csr_pkg::csr_arg_u  st_arg,
    output logic [`CSR_DW-1:0] st_pc,
    output logic               redirect,
    output logic [`CSR_DW-1:0] redirect_pc
);
    import excp_pkg::*;
    import csr_pkg::*;

    logic     int_take;
    logic     accept;
    csr_arg_u int_arg;

    // hold off while the previous redirect is still out
    assign int_take = int_pending && crmd_ie && !redirect;

    // an interrupt goes in even under stall or flush
    assign accept = int_take || (op_valid && !stall && !flush);

    always_comb
    begin
        int_arg             = '0;
        int_arg.cause.ecode = INT;
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            st_valid <= 1'b0;
            st_op    <= NONE;
        end
        else if (accept)
        begin
            st_valid <= 1'b1;
            st_op    <= int_take ? EXCP : op;
        end
        else if (flush)
        begin
            st_valid <= 1'b0;
            st_op    <= NONE;
        end
        else
            st_valid <= 1'b0;   // stalled or idle, contents held
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            st_arg <= int_take ? int_arg : arg;
            st_pc  <= pc;
        end
    end

    // only a plain read leaves the fetch stream alone
    assign redirect = st_valid && st_op != CSRRD && st_op != NONE;

    always_comb
    begin
        case (st_op)
            ERTN:    redirect_pc = era;
            EXCP:    redirect_pc = eentry;
            default: redirect_pc = st_pc + `CSR_DW'd4;
        endcase
    end

endmodule

//--- design/csr_pkg.sv
`include "csr_defs.svh"

package csr_pkg;

    typedef enum logic [`CSR_NUM_W-1:0]
    {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_BADV   = 14'h007,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_num_e;

    typedef struct packed
    {
        logic [1:0] rsvd;
        csr_num_e   num;
    } csr_sel_t;

    typedef struct packed
    {
        logic       rsvd;
        logic [8:0] esubcode;
        logic [5:0] ecode;
    } excp_cause_t;

    // csr ops name a register, exception ops carry their cause
    typedef union packed
    {
        csr_sel_t    csr;
        excp_cause_t cause;
    } csr_arg_u;

endpackage

//--- design/csr_regfile.sv
`include "csr_defs.svh"

module csr_regfile
(
    input  logic                    clk,
    input  logic                    rstn,
    input  excp_pkg::csr_op_e       op,
    input  csr_pkg::csr_arg_u       arg,
    input  logic [`CSR_DW-1:0]      wdata,
    input  logic [`CSR_DW-1:0]      wmask,
    input  logic                    st_valid,
    input  excp_pkg::csr_op_e       st_op,
    input  csr_pkg::csr_arg_u       st_arg,
    input  logic [`CSR_DW-1:0]      st_pc,
    input  logic [`CSR_HWI_N-1:0]   hw_int,
    input  logic                    timer_int,
    input  logic [`CSR_TIMER_W-1:0] tval,
    output logic [`CSR_DW-1:0]      rdata,
    output logic                    int_pending,
    output logic                    crmd_ie,
    output logic [`CSR_DW-1:0]      era,
    output logic [`CSR_DW-1:0]      eentry,
    output logic [8:0]              crmd,
    output logic                    tcfg_we,
    output logic [`CSR_TIMER_W-1:0] tcfg,
    output logic                    ti_clear
);
    import excp_pkg::*;
    import csr_pkg::*;

    logic [2:0]                prmd;
    logic [9:0]                ecfg_lie;   // hw lines over sw bits
    logic                      ecfg_ti;
    logic [1:0]                estat_is;
    logic [5:0]                estat_ecode;
    logic [8:0]                estat_esub;
    logic [`CSR_DW-1:0]        estat;
    logic [`CSR_DW-1:0]        badv;
    logic [`CSR_DW-7:0]        eentry_hi;
    logic [3:0][`CSR_DW-1:0]   save;
    logic [`CSR_DW-1:0]        tid;
    logic [`CSR_DW-1:0]        rd_val;
    logic [`CSR_DW-1:0]        mask;
    logic [`CSR_DW-1:0]        rd_q;
    logic [`CSR_DW-1:0]        wd_q;
    logic [`CSR_DW-1:0]        rd_hold;
    logic                      wr_stage;

    assign crmd_ie = crmd[2];
    assign eentry  = {eentry_hi, 6'b0};
    assign estat   = {1'b0, estat_esub, estat_ecode, 4'b0, timer_int, 1'b0, hw_int, estat_is};

    assign int_pending = |({timer_int, hw_int, estat_is} & {ecfg_ti, ecfg_lie});

    always_comb
    begin
        case (arg.csr.num)
            CSR_CRMD:   rd_val = {23'b0, crmd};
            CSR_PRMD:   rd_val = {29'b0, prmd};
            CSR_ECFG:   rd_val = {20'b0, ecfg_ti, 1'b0, ecfg_lie};
            CSR_ESTAT:  rd_val = estat;
            CSR_ERA:    rd_val = era;
            CSR_BADV:   rd_val = badv;
            CSR_EENTRY: rd_val = eentry;
            CSR_SAVE0:  rd_val = save[0];
            CSR_SAVE1:  rd_val = save[1];
            CSR_SAVE2:  rd_val = save[2];
            CSR_SAVE3:  rd_val = save[3];
            CSR_TID:    rd_val = tid;
            CSR_TCFG:   rd_val = `CSR_DW'(tcfg);
            CSR_TVAL:   rd_val = `CSR_DW'(tval);
            default:    rd_val = '0;   // TICLR reads zero
        endcase
    end

    assign mask = (op == CSRXCHG) ? wmask : '1;

    // sampled each edge, meaningful only in the stage cycle
    always_ff @(posedge clk)
    begin
        rd_q <= rd_val;
        wd_q <= (rd_val & ~mask) | (wdata & mask);
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
            rd_hold <= '0;
        else if (st_valid)
            rd_hold <= rd_q;
    end

    assign rdata = st_valid ? rd_q : rd_hold;

    assign wr_stage = st_valid && (st_op == CSRWR || st_op == CSRXCHG);
    assign ti_clear = wr_stage && st_arg.csr.num == CSR_TICLR && wd_q[0];

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd        <= `CSR_CRMD_RST;
            prmd        <= '0;
            ecfg_lie    <= '0;
            ecfg_ti     <= 1'b0;
            estat_is    <= '0;
            estat_ecode <= '0;
            estat_esub  <= '0;
            era         <= '0;
            badv        <= '0;
            eentry_hi   <= '0;
            save        <= '0;
            tid         <= '0;
            tcfg        <= '0;
            tcfg_we     <= 1'b0;
        end
        else
        begin
            tcfg_we <= wr_stage && st_arg.csr.num == CSR_TCFG;
            if (st_valid)
            begin
                case (st_op)
                    CSRWR, CSRXCHG:
                    begin
                        case (st_arg.csr.num)
                            CSR_CRMD:   crmd <= wd_q[8:0];
                            CSR_PRMD:   prmd <= wd_q[2:0];
                            CSR_ECFG:
                            begin
                                ecfg_ti  <= wd_q[11];
                                ecfg_lie <= wd_q[9:0];
                            end
                            CSR_ESTAT:  estat_is <= wd_q[1:0];   // sw bits only
                            CSR_ERA:    era <= wd_q;
                            CSR_BADV:   badv <= wd_q;
                            CSR_EENTRY: eentry_hi <= wd_q[`CSR_DW-1:6];
                            CSR_SAVE0:  save[0] <= wd_q;
                            CSR_SAVE1:  save[1] <= wd_q;
                            CSR_SAVE2:  save[2] <= wd_q;
                            CSR_SAVE3:  save[3] <= wd_q;
                            CSR_TID:    tid <= wd_q;
                            CSR_TCFG:   tcfg <= wd_q[`CSR_TIMER_W-1:0];
                            default: ;
                        endcase
                    end
                    ERTN:
                        crmd[2:0] <= prmd;
                    EXCP:
                    begin
                        prmd        <= crmd[2:0];
                        crmd[2:0]   <= 3'b000;   // kernel, interrupts off
                        era         <= st_pc;
                        estat_ecode <= st_arg.cause.ecode;
                        estat_esub  <= st_arg.cause.esubcode;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- design/csr_timer.sv
`include "csr_defs.svh"

module csr_timer
(
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    tcfg_we,
    input  logic [`CSR_TIMER_W-1:0] tcfg,
    input  logic                    ti_clear,
    output logic                    timer_int,
    output logic [`CSR_TIMER_W-1:0] tval
);
    logic                    enable;
    logic                    periodic;
    logic [`CSR_TIMER_W-1:0] init_val;
    logic                    hit;

    assign enable   = tcfg[0];
    assign periodic = tcfg[1];
    assign init_val = {tcfg[`CSR_TIMER_W-1:2], 2'b00};

    // last decrement, tval and the bit land on zero together
    assign hit = enable && !tcfg_we && tval == `CSR_TIMER_W'd1;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tval      <= '0;
            timer_int <= 1'b0;
        end
        else
        begin
            if (tcfg_we && enable)
                tval <= init_val;
            else if (enable && tval != '0)
                tval <= tval - 1'b1;
            else if (enable && periodic)
                tval <= init_val;   // periodic wrap, one-shot parks at zero

            if (ti_clear)
                timer_int <= 1'b0;
            else if (hit)
                timer_int <= 1'b1;
        end
    end

endmodule

//--- design/csr_top.sv
`include "csr_defs.svh"

module csr_top
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  op_valid,
    input  excp_pkg::csr_op_e     op,
    input  csr_pkg::csr_arg_u     arg,
    input  logic [`CSR_DW-1:0]    pc,
    input  logic [`CSR_DW-1:0]    wdata,
    input  logic [`CSR_DW-1:0]    wmask,
    input  logic                  stall,
    input  logic                  flush,
    input  logic [`CSR_HWI_N-1:0] hw_int,
    output logic [`CSR_DW-1:0]    rdata,
    output logic                  redirect,
    output logic [`CSR_DW-1:0]    redirect_pc,
    output logic [8:0]            crmd
);
    import excp_pkg::*;
    import csr_pkg::*;

    logic                    st_valid;
    csr_op_e                 st_op;
    csr_arg_u                st_arg;
    logic [`CSR_DW-1:0]      st_pc;
    logic                    int_pending;
    logic                    crmd_ie;
    logic [`CSR_DW-1:0]      era;
    logic [`CSR_DW-1:0]      eentry;
    logic                    tcfg_we;
    logic [`CSR_TIMER_W-1:0] tcfg;
    logic                    ti_clear;
    logic                    timer_int;
    logic [`CSR_TIMER_W-1:0] tval;

    // port names line up across all three blocks
    csr_issue   csr_issue_inst   (.*);
    csr_regfile csr_regfile_inst (.*);
    csr_timer   csr_timer_inst   (.*);

endmodule

//--- design/excp_pkg.sv
package excp_pkg;

    typedef enum logic [2:0]
    {
        NONE    = 3'd0,
        CSRRD   = 3'd1,
        CSRWR   = 3'd2,
        CSRXCHG = 3'd3,
        ERTN    = 3'd4,
        EXCP    = 3'd5
    } csr_op_e;

    // ESTAT.Ecode values
    localparam logic [5:0] INT = 6'h00;   // interrupt
    localparam logic [5:0] SYS = 6'h0b;   // syscall
    localparam logic [5:0] BRK = 6'h0c;   // break
    localparam logic [5:0] INE = 6'h0d;   // bad instruction

endpackage

//--- filelist.f
+incdir+design
design/csr_pkg.sv
design/excp_pkg.sv
design/csr_timer.sv
design/csr_issue.sv
design/csr_regfile.sv
design/csr_top.sv
verif/csr_checker.sv
verif/csr_tb.sv

//--- verif/csr_checker.sv
`include "csr_defs.svh"

module csr_checker
(
    input logic               clk,
    input logic               rstn,
    input logic               st_valid,
    input logic               redirect,
    input logic [`CSR_DW-1:0] rdata
);

    no_redirect_after_reset: assert property (@(posedge clk) $rose(rstn) |-> !redirect)
        else $error("redirect in the first cycle out of reset");

    single_cycle_redirect: assert property (@(posedge clk) disable iff (!rstn)
        redirect |=> !redirect)
        else $error("redirect held for more than one cycle");

    // nothing in the stage, read data must hold
    rdata_held: assert property (@(posedge clk) disable iff (!rstn)
        !st_valid |-> $stable(rdata))
        else $error("rdata changed with no op accepted");

endmodule

bind csr_top csr_checker csr_checker_inst (.clk, .rstn, .st_valid, .redirect, .rdata);

//--- verif/csr_tb.sv
`include "csr_defs.svh"

module csr_tb;
    import excp_pkg::*;
    import csr_pkg::*;

    localparam int TIMER_HEADROOM = 256;   // one-shot count in the data plus slack

    logic                  clk;
    logic                  rstn;
    logic                  op_valid;
    csr_op_e               op;
    csr_arg_u              arg;
    logic [`CSR_DW-1:0]    pc;
    logic [`CSR_DW-1:0]    wdata;
    logic [`CSR_DW-1:0]    wmask;
    logic                  stall;
    logic                  flush;
    logic [`CSR_HWI_N-1:0] hw_int;
    logic [`CSR_DW-1:0]    rdata;
    logic                  redirect;
    logic [`CSR_DW-1:0]    redirect_pc;
    logic [8:0]            crmd;

    // one entry per data line
    logic [31:0] v_op[$];
    logic [31:0] v_arg[$];
    logic [31:0] v_pc[$];
    logic [31:0] v_wdata[$];
    logic [31:0] v_wmask[$];
    logic [31:0] v_hwi[$];
    logic [31:0] v_exp_rd[$];
    logic [31:0] v_exp_pc[$];

    int rdata_errors = 0;
    int redirect_errors = 0;
    int crmd_errors = 0;
    int other_errors = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    csr_top csr_top_inst (.*);

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit)
        begin
            $display("timeout: test still running after %0d cycles", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_rdata(input logic [`CSR_DW-1:0] got, input logic [`CSR_DW-1:0] exp,
                               input int idx);
        if (got !== exp)
        begin
            rdata_errors++;
            $display("[FAIL] %0t line %0d: rdata %h, expected %h", $time, idx, got, exp);
        end
    endtask

    task automatic check_redirect(input logic got, input logic exp_taken,
                                  input logic [`CSR_DW-1:0] got_pc,
                                  input logic [`CSR_DW-1:0] exp_pc, input int idx);
        if (got !== exp_taken)
        begin
            redirect_errors++;
            if (exp_taken)
                $display("[FAIL] %0t line %0d: a redirect pulse was expected but none came",
                         $time, idx);
            else
                $display("[FAIL] %0t line %0d: redirect pulsed on an op that must not redirect",
                         $time, idx);
        end
        else if (exp_taken && got_pc !== exp_pc)
        begin
            redirect_errors++;
            $display("[FAIL] %0t line %0d: redirect_pc %h, expected %h",
                     $time, idx, got_pc, exp_pc);
        end
    endtask

    task automatic check_crmd(input logic [8:0] got, input logic [8:0] exp, input int idx);
        if (got !== exp)
        begin
            crmd_errors++;
            $display("[FAIL] %0t line %0d: crmd %h, expected %h", $time, idx, got, exp);
        end
    endtask

    task automatic load_vectors;
        int          fd;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_arg;
        logic [31:0] f_pc;
        logic [31:0] f_wd;
        logic [31:0] f_wm;
        logic [31:0] f_hw;
        logic [31:0] f_rd;
        logic [31:0] f_rp;
        fd = $fopen("verif/csr_testdata.txt", "r");
        if (fd == 0)
            $display("cannot open verif/csr_testdata.txt");
        else
        begin
            // comment and blank lines give fewer than eight fields
            while ($fgets(line, fd) != 0)
            begin
                if ($sscanf(line, "%h %h %h %h %h %h %h %h",
                            f_op, f_arg, f_pc, f_wd, f_wm, f_hw, f_rd, f_rp) == 8)
                begin
                    v_op.push_back(f_op);
                    v_arg.push_back(f_arg);
                    v_pc.push_back(f_pc);
                    v_wdata.push_back(f_wd);
                    v_wmask.push_back(f_wm);
                    v_hwi.push_back(f_hw);
                    v_exp_rd.push_back(f_rd);
                    v_exp_pc.push_back(f_rp);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_line(input int i);
        csr_op_e cur_op;
        logic    hold;
        logic    exp_redirect;
        cur_op = csr_op_e'(v_op[i][2:0]);
        hold   = v_op[i][3];   // present under stall
        if (cur_op == NONE)
        begin
            // interrupt latency varies, the cycle counter bounds it
            do
                @(negedge clk);
            while (redirect !== 1'b1);
            check_redirect(redirect, 1'b1, redirect_pc, v_exp_pc[i], i);
        end
        else
        begin
            @(posedge clk);
            op_valid <= 1'b1;
            op       <= cur_op;
            arg      <= csr_arg_u'(v_arg[i][15:0]);
            pc       <= v_pc[i];
            wdata    <= v_wdata[i];
            wmask    <= v_wmask[i];
            hw_int   <= v_hwi[i][`CSR_HWI_N-1:0];
            stall    <= hold;
            @(posedge clk);   // acceptance edge
            op_valid <= 1'b0;
            stall    <= 1'b0;
            @(negedge clk);
            exp_redirect = !hold && cur_op != CSRRD;
            check_redirect(redirect, exp_redirect, redirect_pc, v_exp_pc[i], i);
            if (!hold && (cur_op == CSRRD || cur_op == CSRWR || cur_op == CSRXCHG))
                check_rdata(rdata, v_exp_rd[i], i);
            // crmd port must agree with a CSR read of CRMD
            if (!hold && cur_op == CSRRD && v_arg[i][`CSR_NUM_W-1:0] == CSR_CRMD)
                check_crmd(crmd, v_exp_rd[i][8:0], i);
        end
    endtask

    initial
    begin
        clk      = 1'b0;
        rstn     = 1'b0;
        op_valid = 1'b0;
        op       = NONE;
        arg      = '0;
        pc       = '0;
        wdata    = '0;
        wmask    = '0;
        stall    = 1'b0;
        flush    = 1'b0;
        hw_int   = '0;
        load_vectors();
        if (v_op.size() == 0)
        begin
            other_errors++;
            $display("no test vectors were loaded, nothing was run");
        end
        cycle_limit = 40 * v_op.size() + TIMER_HEADROOM;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        for (int i = 0; i < v_op.size(); i++)
            run_line(i);
        repeat (2) @(posedge clk);
        $display("errors: %0d rdata, %0d redirect, %0d crmd, %0d other",
                 rdata_errors, redirect_errors, crmd_errors, other_errors);
        if (rdata_errors + redirect_errors + crmd_errors + other_errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- verif/csr_testdata.txt
# op arg pc wdata wmask hw_int exp_rdata exp_redirect_pc, all hex
# op 1 rd 2 wr 3 xchg 4 ertn 5 excp, 0 waits for an interrupt, +8 presents it under stall
2 0030 00001000 12345678 00000000 00 00000000 00001004
1 0030 00001008 00000000 00000000 00 12345678 00000000
2 0031 00001010 deadbeef 00000000 00 00000000 00001014
2 0032 00001018 a5a5a5a5 00000000 00 00000000 0000101c
2 0033 00001020 0f0f0f0f 00000000 00 00000000 00001024
1 0033 00001028 00000000 00000000 00 0f0f0f0f 00000000
2 0040 00001030 cafe0001 00000000 00 00000000 00001034
1 0040 00001038 00000000 00000000 00 cafe0001 00000000
2 000c 00001040 80001234 00000000 00 00000000 00001044
1 000c 00001048 00000000 00000000 00 80001200 00000000
2 0006 00001050 00002000 00000000 00 00000000 00001054
1 0006 00001058 00000000 00000000 00 00002000 00000000
3 0031 00001060 0000ffff 00ff00ff 00 deadbeef 00001064
1 0031 00001068 00000000 00000000 00 de00beff 00000000
a 0032 00001070 11111111 00000000 00 00000000 00000000
1 0032 00001078 00000000 00000000 00 a5a5a5a5 00000000
2 0000 00001080 0000000f 00000000 00 00000008 00001084
5 014b 00001088 00000000 00000000 00 00000000 80001200
1 0001 00001090 00000000 00000000 00 00000007 00000000
1 0000 00001098 00000000 00000000 00 00000008 00000000
1 0006 000010a0 00000000 00000000 00 00001088 00000000
1 0005 000010a8 00000000 00000000 05 014b0014 00000000
4 0000 000010b0 00000000 00000000 00 00000000 00001088
1 0000 000010b8 00000000 00000000 00 0000000f 00000000
2 0004 000010c0 00000800 00000000 00 00000000 000010c4
2 0041 000010c8 00000021 00000000 00 00000000 000010cc
0 0000 00000000 00000000 00000000 00 00000000 80001200
1 0005 000010d0 00000000 00000000 00 00000800 00000000
2 0044 000010d8 00000001 00000000 00 00000000 000010dc
1 0005 000010e0 00000000 00000000 00 00000000 00000000
1 0000 000010e8 00000000 00000000 00 00000008 00000000
